// File: logic/mem_chip_cfg_pkg.sv
// Memory chip configuration
// Datapath widths, memory sizes and clock-division reset values

`default_nettype none

package mem_chip_cfg_pkg;

  // Request datapath
  localparam int unsigned AddrWidth   = 48;
  localparam int unsigned ChipIdWidth = 8;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned StrbWidth   = 8;

  // Memory sizes in bytes
  localparam int unsigned NarrowSpmBytes = 32'h8000;
  localparam int unsigned WideSramBytes  = 32'h10000;

  // Clock-division register page
  localparam int unsigned NumClkDivs  = 5;
  localparam int unsigned ClkDivWidth = 8;

  // Entry 0 divides the SRAM clock, the rest run undivided
  localparam logic [NumClkDivs-1:0][ClkDivWidth-1:0] ClkDivDefault = {
    8'd1, 8'd1, 8'd1, 8'd1, 8'd4
  };

endpackage

`default_nettype wire

// File: logic/mem_chip_addr_pkg.sv
// Memory chip address map
// Local window bases, target codes and the two views of a local offset

`default_nettype none

package mem_chip_addr_pkg;

  // Offset below the chip field
  localparam int unsigned LocalWidth = 40;

  //////////////////////////////
  // Address map
  //////////////////////////////

  localparam logic [LocalWidth-1:0] NarrowSpmBase   = 40'h00_7000_0000;
  localparam logic [LocalWidth-1:0] WideSramBase    = 40'h00_8000_0000;
  localparam logic [LocalWidth-1:0] ClkDivBase      = 40'h00_0200_5000;
  localparam logic [LocalWidth-1:0] ClkDivPageBytes = 40'h00_0000_1000;

  // Response targets
  localparam logic [1:0] TgtNarrow = 2'd0;
  localparam logic [1:0] TgtWide   = 2'd1;
  localparam logic [1:0] TgtRegs   = 2'd2;
  localparam logic [1:0] TgtNone   = 2'd3;

  //////////////////////////////
  // Local offset views
  //////////////////////////////

  typedef struct packed {
    logic [LocalWidth-4:0] word;
    logic [2:0]            byte_off;
  } mem_view_t;

  // 4 KiB page, 64-bit registers
  typedef struct packed {
    logic [LocalWidth-13:0] page;
    logic [8:0]             reg_idx;
    logic [2:0]             byte_off;
  } reg_view_t;

  typedef union packed {
    mem_view_t mem;
    reg_view_t regs;
  } local_offset_t;

endpackage

`default_nettype wire

// File: logic/mem_chip_addr_decode.sv
// Request decoder of the memory chip
// Captures the chip ID in reset, forwards remote requests to the die-to-die
// port and steers local requests to the scratchpad, the SRAM or the registers

`timescale 1ns/1ns
`default_nettype none

module mem_chip_addr_decode (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [mem_chip_cfg_pkg::ChipIdWidth-1:0] chip_id_i,
  input  logic                                     req_valid_i,
  input  logic                                     req_we_i,
  input  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0]   req_wdata_i,
  input  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   req_strb_i,
  output logic                                     narrow_req_o,
  output logic                                     wide_req_o,
  output logic                                     regs_req_o,
  output logic                                     we_o,
  output logic [12:0]                              word_idx_o,
  output logic [8:0]                               reg_idx_o,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0]   wdata_o,
  output logic [mem_chip_cfg_pkg::StrbWidth-1:0]   strb_o,
  output logic                                     local_vld_o,
  output logic [1:0]                               tgt_o,
  output logic                                     d2d_valid_o,
  output logic                                     d2d_we_o,
  output logic [mem_chip_cfg_pkg::AddrWidth-1:0]   d2d_addr_o,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0]   d2d_wdata_o,
  output logic [mem_chip_cfg_pkg::StrbWidth-1:0]   d2d_strb_o
);

  logic [mem_chip_cfg_pkg::ChipIdWidth-1:0] chip_id_q;
  mem_chip_addr_pkg::local_offset_t         local_off;
  logic                                     is_local;
  logic [1:0]                               tgt_d;
  logic narrow_q, wide_q, regs_q, local_q, d2d_q;
  logic                                     we_q;
  logic [12:0]                              word_idx_q;
  logic [8:0]                               reg_idx_q;
  logic [mem_chip_cfg_pkg::DataWidth-1:0]   wdata_q;
  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   strb_q;
  logic [1:0]                               tgt_q;
  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   addr_q;

  function automatic logic in_window(input logic [39:0] off, input logic [39:0] base,
                                     input logic [39:0] size);
    return (off >= base) && (off < base + size);
  endfunction

  // Chip ID follows the pins while reset is held
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  assign local_off = req_addr_i[mem_chip_addr_pkg::LocalWidth-1:0];
  assign is_local  = req_addr_i[mem_chip_cfg_pkg::AddrWidth-1 -:
                                mem_chip_cfg_pkg::ChipIdWidth] == chip_id_q;

  always_comb begin
    if (in_window(local_off, mem_chip_addr_pkg::NarrowSpmBase,
                  40'(mem_chip_cfg_pkg::NarrowSpmBytes))) begin
      tgt_d = mem_chip_addr_pkg::TgtNarrow;
    end else if (in_window(local_off, mem_chip_addr_pkg::WideSramBase,
                           40'(mem_chip_cfg_pkg::WideSramBytes))) begin
      tgt_d = mem_chip_addr_pkg::TgtWide;
    end else if (in_window(local_off, mem_chip_addr_pkg::ClkDivBase,
                           mem_chip_addr_pkg::ClkDivPageBytes)) begin
      tgt_d = mem_chip_addr_pkg::TgtRegs;
    end else begin
      tgt_d = mem_chip_addr_pkg::TgtNone;
    end
  end

  //////////////////////////////
  // Request register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      narrow_q <= 1'b0;
      wide_q   <= 1'b0;
      regs_q   <= 1'b0;
      local_q  <= 1'b0;
      d2d_q    <= 1'b0;
    end else begin
      narrow_q <= req_valid_i && is_local && (tgt_d == mem_chip_addr_pkg::TgtNarrow);
      wide_q   <= req_valid_i && is_local && (tgt_d == mem_chip_addr_pkg::TgtWide);
      regs_q   <= req_valid_i && is_local && (tgt_d == mem_chip_addr_pkg::TgtRegs);
      local_q  <= req_valid_i && is_local;
      d2d_q    <= req_valid_i && !is_local;
    end
  end

  // Payload is shared by the local targets and the die-to-die port
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      we_q       <= req_we_i;
      word_idx_q <= local_off.mem.word[12:0];
      reg_idx_q  <= local_off.regs.reg_idx;
      wdata_q    <= req_wdata_i;
      strb_q     <= req_strb_i;
      tgt_q      <= tgt_d;
      addr_q     <= req_addr_i;
    end
  end

  assign narrow_req_o = narrow_q;
  assign wide_req_o   = wide_q;
  assign regs_req_o   = regs_q;
  assign local_vld_o  = local_q;
  assign we_o         = we_q;
  assign word_idx_o   = word_idx_q;
  assign reg_idx_o    = reg_idx_q;
  assign wdata_o      = wdata_q;
  assign strb_o       = strb_q;
  assign tgt_o        = tgt_q;
  assign d2d_valid_o  = d2d_q;
  assign d2d_we_o     = we_q;
  assign d2d_addr_o   = addr_q;
  assign d2d_wdata_o  = wdata_q;
  assign d2d_strb_o   = strb_q;

endmodule

`default_nettype wire

// File: logic/mem_chip_spm.sv
// Single-port word memory with byte enables
// Read data is registered, writes touch only the enabled bytes

`timescale 1ns/1ns
`default_nettype none

module mem_chip_spm #(
  parameter int unsigned NumWords = 4096
) (
  input  logic                                   clk_i,
  input  logic                                   valid_i,
  input  logic                                   we_i,
  input  logic [12:0]                            addr_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0] wdata_i,
  input  logic [mem_chip_cfg_pkg::StrbWidth-1:0] be_i,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0] rdata_o
);

  logic [mem_chip_cfg_pkg::DataWidth-1:0] mem_q [NumWords];
  logic [mem_chip_cfg_pkg::DataWidth-1:0] rdata_q;
  logic [$clog2(NumWords)-1:0]            idx;

  // Smaller instances ignore the upper index bits
  assign idx = addr_i[$clog2(NumWords)-1:0];

  always_ff @(posedge clk_i) begin
    if (valid_i && we_i) begin
      for (int b = 0; b < mem_chip_cfg_pkg::StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !we_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: logic/mem_chip_clk_div_regs.sv
// Clock-division register page
// Five division values, a written zero is kept as one

`timescale 1ns/1ns
`default_nettype none

module mem_chip_clk_div_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   valid_i,
  input  logic                                   we_i,
  input  logic [8:0]                             reg_idx_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0] wdata_i,
  input  logic [mem_chip_cfg_pkg::StrbWidth-1:0] be_i,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0] rdata_o,
  output logic                                   err_o
);

  logic [mem_chip_cfg_pkg::NumClkDivs-1:0][mem_chip_cfg_pkg::ClkDivWidth-1:0] div_q;
  logic [mem_chip_cfg_pkg::ClkDivWidth-1:0] sel_div;
  logic [mem_chip_cfg_pkg::ClkDivWidth-1:0] wr_val;
  logic [mem_chip_cfg_pkg::DataWidth-1:0]   rdata_q;
  logic                                     idx_ok;
  logic                                     err_q;

  assign idx_ok = reg_idx_i < 9'(mem_chip_cfg_pkg::NumClkDivs);
  assign wr_val = (wdata_i[mem_chip_cfg_pkg::ClkDivWidth-1:0] == '0) ?
                  mem_chip_cfg_pkg::ClkDivWidth'(1) :
                  wdata_i[mem_chip_cfg_pkg::ClkDivWidth-1:0];

  always_comb begin
    sel_div = '0;
    for (int i = 0; i < mem_chip_cfg_pkg::NumClkDivs; i++) begin
      if (reg_idx_i == 9'(i)) begin
        sel_div = div_q[i];
      end
    end
  end

  // Unknown indices match no entry
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      div_q <= mem_chip_cfg_pkg::ClkDivDefault;
      err_q <= 1'b0;
    end else begin
      err_q <= valid_i && !idx_ok;
      if (valid_i && we_i && be_i[0]) begin
        for (int i = 0; i < mem_chip_cfg_pkg::NumClkDivs; i++) begin
          if (reg_idx_i == 9'(i)) begin
            div_q[i] <= wr_val;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rdata_q <= mem_chip_cfg_pkg::DataWidth'(sel_div);
    end
  end

  assign rdata_o = err_q ? '0 : rdata_q;
  assign err_o   = err_q;

endmodule

`default_nettype wire

// File: logic/mem_chip_rsp_mux.sv
// Response stage of the memory chip
// Aligns the target code with the registered read data and builds the response

`timescale 1ns/1ns
`default_nettype none

module mem_chip_rsp_mux (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   local_vld_i,
  input  logic [1:0]                             tgt_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0] narrow_rdata_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0] wide_rdata_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0] regs_rdata_i,
  input  logic                                   regs_err_i,
  input  logic                                   we_i,
  output logic                                   rsp_valid_o,
  output logic                                   rsp_err_o,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0] rsp_rdata_o
);

  logic       valid_q;
  logic [1:0] tgt_q;
  logic       we_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= local_vld_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (local_vld_i) begin
      tgt_q <= tgt_i;
      we_q  <= we_i;
    end
  end

  // Unmapped offsets and bad register indices answer with an error
  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = valid_q && ((tgt_q == mem_chip_addr_pkg::TgtNone) ||
                                   ((tgt_q == mem_chip_addr_pkg::TgtRegs) && regs_err_i));

  always_comb begin
    rsp_rdata_o = '0;
    if (valid_q && !we_q) begin
      case (tgt_q)
        mem_chip_addr_pkg::TgtNarrow: rsp_rdata_o = narrow_rdata_i;
        mem_chip_addr_pkg::TgtWide:   rsp_rdata_o = wide_rdata_i;
        mem_chip_addr_pkg::TgtRegs:   rsp_rdata_o = regs_rdata_i;
        default:                      rsp_rdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_chip_top.sv
// Memory chip request path
// Decoder, scratchpad, wide SRAM, clock-division registers and response stage

`timescale 1ns/1ns
`default_nettype none

module mem_chip_top (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [mem_chip_cfg_pkg::ChipIdWidth-1:0] chip_id_i,
  input  logic                                     req_valid_i,
  input  logic                                     req_we_i,
  input  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0]   req_wdata_i,
  input  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   req_strb_i,
  output logic                                     rsp_valid_o,
  output logic                                     rsp_err_o,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0]   rsp_rdata_o,
  output logic                                     d2d_valid_o,
  output logic                                     d2d_we_o,
  output logic [mem_chip_cfg_pkg::AddrWidth-1:0]   d2d_addr_o,
  output logic [mem_chip_cfg_pkg::DataWidth-1:0]   d2d_wdata_o,
  output logic [mem_chip_cfg_pkg::StrbWidth-1:0]   d2d_strb_o
);

  logic                                   narrow_req, wide_req, regs_req;
  logic                                   req_we;
  logic [12:0]                            word_idx;
  logic [8:0]                             reg_idx;
  logic [mem_chip_cfg_pkg::DataWidth-1:0] wdata;
  logic [mem_chip_cfg_pkg::StrbWidth-1:0] strb;
  logic                                   local_vld;
  logic [1:0]                             rsp_tgt;
  logic [mem_chip_cfg_pkg::DataWidth-1:0] narrow_rdata, wide_rdata, regs_rdata;
  logic                                   regs_err;

  mem_chip_addr_decode i_decode (
    .clk_i, .rst_ni, .chip_id_i,
    .req_valid_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_strb_i,
    .narrow_req_o (narrow_req),
    .wide_req_o   (wide_req),
    .regs_req_o   (regs_req),
    .we_o         (req_we),
    .word_idx_o   (word_idx),
    .reg_idx_o    (reg_idx),
    .wdata_o      (wdata),
    .strb_o       (strb),
    .local_vld_o  (local_vld),
    .tgt_o        (rsp_tgt),
    .d2d_valid_o, .d2d_we_o, .d2d_addr_o, .d2d_wdata_o, .d2d_strb_o
  );

  //////////////////////////////
  // Local targets
  //////////////////////////////

  mem_chip_spm #(
    .NumWords(mem_chip_cfg_pkg::NarrowSpmBytes / mem_chip_cfg_pkg::StrbWidth)
  ) i_narrow_spm (
    .clk_i, .valid_i(narrow_req), .we_i(req_we), .addr_i(word_idx),
    .wdata_i(wdata), .be_i(strb), .rdata_o(narrow_rdata)
  );

  mem_chip_spm #(
    .NumWords(mem_chip_cfg_pkg::WideSramBytes / mem_chip_cfg_pkg::StrbWidth)
  ) i_wide_sram (
    .clk_i, .valid_i(wide_req), .we_i(req_we), .addr_i(word_idx),
    .wdata_i(wdata), .be_i(strb), .rdata_o(wide_rdata)
  );

  mem_chip_clk_div_regs i_clk_div_regs (
    .clk_i, .rst_ni, .valid_i(regs_req), .we_i(req_we), .reg_idx_i(reg_idx),
    .wdata_i(wdata), .be_i(strb), .rdata_o(regs_rdata), .err_o(regs_err)
  );

  mem_chip_rsp_mux i_rsp_mux (
    .clk_i, .rst_ni,
    .local_vld_i    (local_vld),
    .tgt_i          (rsp_tgt),
    .narrow_rdata_i (narrow_rdata),
    .wide_rdata_i   (wide_rdata),
    .regs_rdata_i   (regs_rdata),
    .regs_err_i     (regs_err),
    .we_i           (req_we),
    .rsp_valid_o, .rsp_err_o, .rsp_rdata_o
  );

endmodule

`default_nettype wire

// File: tb/tb_mem_chip_props.sv
// Port properties of the memory chip
// Bound to the top level, checks response and forward framing

`timescale 1ns/1ns
`default_nettype none

module tb_mem_chip_props (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   req_valid_i,
  input logic                                   rsp_valid_i,
  input logic                                   rsp_err_i,
  input logic [mem_chip_cfg_pkg::DataWidth-1:0] rsp_rdata_i,
  input logic                                   d2d_valid_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Local requests answer after two cycles, remote ones leave after one
  a_one_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(req_valid_i, 2) |-> (rsp_valid_i != $past(d2d_valid_i)))
    else begin
      $error("Request did not leave by exactly one of response and forward");
      fail_cnt++;
    end

  a_err_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_err_i |-> rsp_valid_i)
    else begin
      $error("Error flag raised without a response");
      fail_cnt++;
    end

  a_err_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_err_i |-> (rsp_rdata_i == '0))
    else begin
      $error("Error response carries nonzero read data");
      fail_cnt++;
    end

endmodule

bind mem_chip_top tb_mem_chip_props i_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_valid_i (req_valid_i),
  .rsp_valid_i (rsp_valid_o),
  .rsp_err_i   (rsp_err_o),
  .rsp_rdata_i (rsp_rdata_o),
  .d2d_valid_i (d2d_valid_o)
);

`default_nettype wire

// File: tb/tb_mem_chip_checker.sv
// Reference model and output checker of the memory chip
// Predicts every response and forward from the request stream

`timescale 1ns/1ns
`default_nettype none

module tb_mem_chip_checker (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [mem_chip_cfg_pkg::ChipIdWidth-1:0] chip_id_i,
  input  logic                                     req_valid_i,
  input  logic                                     req_we_i,
  input  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0]   req_wdata_i,
  input  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   req_strb_i,
  input  logic                                     rsp_valid_i,
  input  logic                                     rsp_err_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0]   rsp_rdata_i,
  input  logic                                     d2d_valid_i,
  input  logic                                     d2d_we_i,
  input  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   d2d_addr_i,
  input  logic [mem_chip_cfg_pkg::DataWidth-1:0]   d2d_wdata_i,
  input  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   d2d_strb_i,
  output int unsigned                              rsp_errs_o,
  output int unsigned                              fwd_errs_o,
  output int unsigned                              rsp_checked_o,
  output int unsigned                              fwd_checked_o
);

  localparam int unsigned NarrowWords = mem_chip_cfg_pkg::NarrowSpmBytes / 8;
  localparam int unsigned WideWords   = mem_chip_cfg_pkg::WideSramBytes / 8;
  localparam int unsigned NarrowIdxW  = $clog2(NarrowWords);
  localparam int unsigned WideIdxW    = $clog2(WideWords);

  logic [7:0]  own_id;
  logic [63:0] narrow_m [NarrowWords];
  logic [63:0] wide_m   [WideWords];
  logic [mem_chip_cfg_pkg::NumClkDivs-1:0][mem_chip_cfg_pkg::ClkDivWidth-1:0] div_m;

  // Entry 1 of the response line is due in the current cycle
  logic        exp_rsp_v    [2];
  logic        exp_rsp_err  [2];
  logic [63:0] exp_rsp_data [2];
  string       exp_rsp_name [2];
  logic        exp_fwd_v;
  logic        exp_fwd_we;
  logic [47:0] exp_fwd_addr;
  logic [63:0] exp_fwd_wdata;
  logic [7:0]  exp_fwd_strb;

  int unsigned rsp_errs    = 0;
  int unsigned fwd_errs    = 0;
  int unsigned rsp_checked = 0;
  int unsigned fwd_checked = 0;

  function automatic logic in_range(input logic [39:0] off, input logic [39:0] base,
                                    input logic [39:0] size);
    return (off >= base) && (off < base + size);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] wdata,
                                              input logic [7:0]  strb);
    logic [63:0] res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic int unsigned mismatch(input string name, input logic [63:0] exp_val,
                                           input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
      return 1;
    end
    return 0;
  endfunction

  //////////////////////////////
  // Local request model
  //////////////////////////////

  task automatic predict_local();
    logic [39:0]           off;
    logic [NarrowIdxW-1:0] n_idx;
    logic [WideIdxW-1:0]   w_idx;
    logic [8:0]            r_idx;
    string                 kind;
    off   = req_addr_i[39:0];
    n_idx = NarrowIdxW'((off - mem_chip_addr_pkg::NarrowSpmBase) >> 3);
    w_idx = WideIdxW'((off - mem_chip_addr_pkg::WideSramBase) >> 3);
    r_idx = 9'((off - mem_chip_addr_pkg::ClkDivBase) >> 3);
    kind  = req_we_i ? " write" : " read";
    exp_rsp_v[0]    = 1'b1;
    exp_rsp_err[0]  = 1'b0;
    exp_rsp_data[0] = '0;
    if (in_range(off, mem_chip_addr_pkg::NarrowSpmBase,
                 40'(mem_chip_cfg_pkg::NarrowSpmBytes))) begin
      exp_rsp_name[0] = {"narrow", kind};
      if (req_we_i) begin
        narrow_m[n_idx] = merge_bytes(narrow_m[n_idx], req_wdata_i, req_strb_i);
      end else begin
        exp_rsp_data[0] = narrow_m[n_idx];
      end
    end else if (in_range(off, mem_chip_addr_pkg::WideSramBase,
                          40'(mem_chip_cfg_pkg::WideSramBytes))) begin
      exp_rsp_name[0] = {"wide", kind};
      if (req_we_i) begin
        wide_m[w_idx] = merge_bytes(wide_m[w_idx], req_wdata_i, req_strb_i);
      end else begin
        exp_rsp_data[0] = wide_m[w_idx];
      end
    end else if (in_range(off, mem_chip_addr_pkg::ClkDivBase,
                          mem_chip_addr_pkg::ClkDivPageBytes)) begin
      exp_rsp_name[0] = {"regs", kind};
      if (r_idx >= 9'(mem_chip_cfg_pkg::NumClkDivs)) begin
        exp_rsp_err[0] = 1'b1;
      end else if (req_we_i) begin
        if (req_strb_i[0]) begin
          // Division by zero is stored as division by one
          div_m[3'(r_idx)] = (req_wdata_i[7:0] == 8'h00) ? 8'h01 : req_wdata_i[7:0];
        end
      end else begin
        exp_rsp_data[0] = 64'(div_m[3'(r_idx)]);
      end
    end else begin
      exp_rsp_name[0] = {"unmapped", kind};
      exp_rsp_err[0]  = 1'b1;
    end
  endtask

  task automatic check_outputs();
    if (exp_rsp_v[1] && rsp_valid_i !== 1'b1) begin
      $display("Missing response for a %s request", exp_rsp_name[1]);
      rsp_errs++;
    end else if (!exp_rsp_v[1] && rsp_valid_i !== 1'b0) begin
      $display("Response without a local request two cycles earlier");
      rsp_errs++;
    end else if (exp_rsp_v[1]) begin
      rsp_checked++;
      rsp_errs += mismatch({exp_rsp_name[1], " error"}, 64'(exp_rsp_err[1]), 64'(rsp_err_i));
      rsp_errs += mismatch({exp_rsp_name[1], " rdata"}, exp_rsp_data[1], rsp_rdata_i);
    end
    if (exp_fwd_v && d2d_valid_i !== 1'b1) begin
      $display("Missing forward of a remote request");
      fwd_errs++;
    end else if (!exp_fwd_v && d2d_valid_i !== 1'b0) begin
      $display("Forward without a remote request one cycle earlier");
      fwd_errs++;
    end else if (exp_fwd_v) begin
      fwd_checked++;
      fwd_errs += mismatch("remote we", 64'(exp_fwd_we), 64'(d2d_we_i));
      fwd_errs += mismatch("remote addr", 64'(exp_fwd_addr), 64'(d2d_addr_i));
      fwd_errs += mismatch("remote wdata", exp_fwd_wdata, d2d_wdata_i);
      fwd_errs += mismatch("remote strb", 64'(exp_fwd_strb), 64'(d2d_strb_i));
    end
  endtask

  // Inputs and outputs are both settled at the falling edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      own_id       = chip_id_i;
      div_m        = mem_chip_cfg_pkg::ClkDivDefault;
      exp_rsp_v[0] = 1'b0;
      exp_rsp_v[1] = 1'b0;
      exp_fwd_v    = 1'b0;
      if (rsp_valid_i !== 1'b0 || d2d_valid_i !== 1'b0) begin
        $display("Valid output is high during reset");
        rsp_errs++;
      end
    end else begin
      check_outputs();
      exp_rsp_v[1]    = exp_rsp_v[0];
      exp_rsp_err[1]  = exp_rsp_err[0];
      exp_rsp_data[1] = exp_rsp_data[0];
      exp_rsp_name[1] = exp_rsp_name[0];
      exp_rsp_v[0]    = 1'b0;
      exp_fwd_v       = 1'b0;
      if (req_valid_i) begin
        if (req_addr_i[47:40] != own_id) begin
          exp_fwd_v     = 1'b1;
          exp_fwd_we    = req_we_i;
          exp_fwd_addr  = req_addr_i;
          exp_fwd_wdata = req_wdata_i;
          exp_fwd_strb  = req_strb_i;
        end else begin
          predict_local();
        end
      end
    end
  end

  assign rsp_errs_o    = rsp_errs;
  assign fwd_errs_o    = fwd_errs;
  assign rsp_checked_o = rsp_checked;
  assign fwd_checked_o = fwd_checked;

endmodule

`default_nettype wire

// File: tb/tb_mem_chip.sv
// Testbench of the memory chip request path
// Directed register reads, memory preload and seeded random traffic

`timescale 1ns/1ns
`default_nettype none

module tb_mem_chip;

  localparam int unsigned ClkPeriod    = 40;
  localparam int unsigned ResetCycles  = 8;
  localparam int unsigned NumWordsUsed = 8;
  localparam int unsigned NumCycles    = 800;
  // Reset, register reads, preload, random traffic and drain
  localparam int unsigned TotalCycles  = ResetCycles + 8 + 2 * NumWordsUsed + NumCycles + 6;
  localparam int unsigned TimeoutNs    = (TotalCycles + 50) * ClkPeriod;

  logic                                     clk;
  logic                                     rst_n;
  logic [mem_chip_cfg_pkg::ChipIdWidth-1:0] chip_id;
  logic                                     req_valid;
  logic                                     req_we;
  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   req_addr;
  logic [mem_chip_cfg_pkg::DataWidth-1:0]   req_wdata;
  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   req_strb;
  logic                                     rsp_valid;
  logic                                     rsp_err;
  logic [mem_chip_cfg_pkg::DataWidth-1:0]   rsp_rdata;
  logic                                     d2d_valid;
  logic                                     d2d_we;
  logic [mem_chip_cfg_pkg::AddrWidth-1:0]   d2d_addr;
  logic [mem_chip_cfg_pkg::DataWidth-1:0]   d2d_wdata;
  logic [mem_chip_cfg_pkg::StrbWidth-1:0]   d2d_strb;
  logic [7:0]                               own_id;
  int unsigned                              seed_val;
  int unsigned rsp_errs, fwd_errs, rsp_checked, fwd_checked;

  mem_chip_top i_dut (
    .clk_i(clk), .rst_ni(rst_n), .chip_id_i(chip_id),
    .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
    .req_wdata_i(req_wdata), .req_strb_i(req_strb),
    .rsp_valid_o(rsp_valid), .rsp_err_o(rsp_err), .rsp_rdata_o(rsp_rdata),
    .d2d_valid_o(d2d_valid), .d2d_we_o(d2d_we), .d2d_addr_o(d2d_addr),
    .d2d_wdata_o(d2d_wdata), .d2d_strb_o(d2d_strb)
  );

  tb_mem_chip_checker i_checker (
    .clk_i(clk), .rst_ni(rst_n), .chip_id_i(chip_id),
    .req_valid_i(req_valid), .req_we_i(req_we), .req_addr_i(req_addr),
    .req_wdata_i(req_wdata), .req_strb_i(req_strb),
    .rsp_valid_i(rsp_valid), .rsp_err_i(rsp_err), .rsp_rdata_i(rsp_rdata),
    .d2d_valid_i(d2d_valid), .d2d_we_i(d2d_we), .d2d_addr_i(d2d_addr),
    .d2d_wdata_i(d2d_wdata), .d2d_strb_i(d2d_strb),
    .rsp_errs_o(rsp_errs), .fwd_errs_o(fwd_errs),
    .rsp_checked_o(rsp_checked), .fwd_checked_o(fwd_checked)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Holds one request for a single rising edge
  task automatic send_request(input logic we, input logic [47:0] addr,
                              input logic [63:0] wdata, input logic [7:0] strb);
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    req_strb  = strb;
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycle();
    req_valid = 1'b0;
    @(posedge clk);
    #2;
  endtask

  function automatic logic [39:0] unmapped_offset(input logic [1:0] sel);
    case (sel)
      2'd0:    return 40'h0;
      2'd1:    return mem_chip_addr_pkg::NarrowSpmBase + 40'(mem_chip_cfg_pkg::NarrowSpmBytes);
      2'd2:    return mem_chip_addr_pkg::WideSramBase + 40'(mem_chip_cfg_pkg::WideSramBytes);
      default: return mem_chip_addr_pkg::ClkDivBase + mem_chip_addr_pkg::ClkDivPageBytes;
    endcase
  endfunction

  task automatic send_random_request();
    logic [2:0]  kind;
    logic [7:0]  chip;
    logic [39:0] off;
    logic [63:0] wdata;
    chip  = own_id;
    wdata = {$urandom, $urandom};
    kind  = 3'($urandom_range(4));
    case (kind)
      3'd0: begin
        chip = own_id ^ 8'($urandom_range(255, 1));
        off  = {8'($urandom), $urandom} & ~40'h7;
      end
      3'd1: off = mem_chip_addr_pkg::NarrowSpmBase + 40'(8 * $urandom_range(NumWordsUsed - 1));
      3'd2: off = mem_chip_addr_pkg::WideSramBase + 40'(8 * $urandom_range(NumWordsUsed - 1));
      3'd3: begin
        // Indices 5 to 7 land past the last register
        off = mem_chip_addr_pkg::ClkDivBase + 40'(8 * $urandom_range(7));
        if ($urandom_range(3) == 0) begin
          wdata[7:0] = 8'h00;
        end
      end
      default: off = unmapped_offset(2'($urandom_range(3)));
    endcase
    send_request(1'($urandom_range(1)), {chip, off}, wdata, 8'($urandom));
  endtask

  initial begin
    #(TimeoutNs);
    $display("Timeout: no final report after %0d ns", TimeoutNs);
    $display("Something failed");
    $finish;
  end

  initial begin
    seed_val  = $urandom(36);
    clk       = 1'b0;
    rst_n     = 1'b0;
    own_id    = 8'($urandom);
    chip_id   = own_id;
    req_valid = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_strb  = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rst_n   = 1'b1;
    chip_id = own_id ^ 8'($urandom_range(255, 1));

    // Reset values of all indices, the last three are out of range
    for (int i = 0; i < 8; i++) begin
      send_request(1'b0, {own_id, mem_chip_addr_pkg::ClkDivBase + 40'(8 * i)}, '0, '0);
    end
    for (int i = 0; i < NumWordsUsed; i++) begin
      send_request(1'b1, {own_id, mem_chip_addr_pkg::NarrowSpmBase + 40'(8 * i)},
                   {$urandom, $urandom}, 8'hff);
      send_request(1'b1, {own_id, mem_chip_addr_pkg::WideSramBase + 40'(8 * i)},
                   {$urandom, $urandom}, 8'hff);
    end
    for (int c = 0; c < NumCycles; c++) begin
      if ($urandom_range(3) != 0) begin
        send_random_request();
      end else begin
        idle_cycle();
      end
    end
    repeat (6) idle_cycle();

    if (rsp_checked == 0 || fwd_checked == 0) begin
      $display("No responses or no forwards were checked");
    end
    $display("Checked %0d responses, %0d forwards; errors: %0d responses, %0d forwards, %0d %s",
             rsp_checked, fwd_checked, rsp_errs, fwd_errs, i_dut.i_props.fail_cnt,
             "assertions");
    if (rsp_errs == 0 && fwd_errs == 0 && i_dut.i_props.fail_cnt == 0 &&
        rsp_checked != 0 && fwd_checked != 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
logic/mem_chip_cfg_pkg.sv
logic/mem_chip_addr_pkg.sv
logic/mem_chip_addr_decode.sv
logic/mem_chip_spm.sv
logic/mem_chip_clk_div_regs.sv
logic/mem_chip_rsp_mux.sv
logic/mem_chip_top.sv
tb/tb_mem_chip_props.sv
tb/tb_mem_chip_checker.sv
tb/tb_mem_chip.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the memory chip testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f \
  --top-module tb_mem_chip -o sim_mem_chip > build.log 2>&1 \
  && ./obj_dir/sim_mem_chip > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0
